/* hw/fx_data_pkg.sv */
// Data widths are fixed by the SIMD instruction set; lanes are counted from bit 0 upward
package fx_data_pkg;

  // One 128-bit register value, bit 0 least significant
  typedef logic [127:0] quad_t;

  // Word lane i sits at bits 32i upward
  typedef logic [31:0] word_t;

  // Halfword lane i sits at bits 16i upward
  typedef logic [15:0] half_t;

  // Register file has 128 entries
  typedef logic [6:0] reg_addr_t;

  // Raw immediate field, RI10 uses only the low ten bits
  typedef logic [17:0] imm_t;

  // Opcode field as seen on the instruction port
  typedef logic [10:0] opcode_t;

  // Instruction format selector
  typedef logic [2:0] format_t;

  // Signed saturation limits per lane width
  localparam word_t word_max = 32'h7fff_ffff;
  localparam word_t word_min = 32'h8000_0000;
  localparam half_t half_max = 16'h7fff;
  localparam half_t half_min = 16'h8000;

endpackage

/* hw/fx_isa_pkg.sv */
// Only RR and RI10 encodings of the even-pipe fixed-point subset; all other codes decode to none
package fx_isa_pkg;

  import fx_data_pkg::*;

  // Instruction formats handled by this unit
  localparam format_t fmt_rr   = 3'd0;
  localparam format_t fmt_ri10 = 3'd4;

  // RR arithmetic, halfword and word
  localparam opcode_t op_ah  = 11'b00011001000;
  localparam opcode_t op_a   = 11'b00011000000;
  localparam opcode_t op_sfh = 11'b00001001000;
  localparam opcode_t op_sf  = 11'b00001000000;

  // RR quadword logic
  localparam opcode_t op_and  = 11'b00011000001;
  localparam opcode_t op_or   = 11'b00001000001;
  localparam opcode_t op_xor  = 11'b01001000001;
  localparam opcode_t op_nand = 11'b00011001001;

  // RR compares, signed
  localparam opcode_t op_ceqh = 11'b01111001000;
  localparam opcode_t op_ceq  = 11'b01111000000;
  localparam opcode_t op_cgth = 11'b01001001000;
  localparam opcode_t op_cgt  = 11'b01001000000;

  // RI10 codes live in the low eight opcode bits
  localparam opcode_t op_ahi   = 11'b000_00011101;
  localparam opcode_t op_ai    = 11'b000_00011100;
  localparam opcode_t op_sfhi  = 11'b000_00001101;
  localparam opcode_t op_sfi   = 11'b000_00001100;
  localparam opcode_t op_ceqhi = 11'b000_01111101;
  localparam opcode_t op_ceqi  = 11'b000_01111100;
  localparam opcode_t op_cgthi = 11'b000_01001101;
  localparam opcode_t op_cgti  = 11'b000_01001100;

  // Decoded operation, RR and immediate forms collapse onto one value
  typedef enum logic [3:0] {
    op_none,
    op_add_h,
    op_add_w,
    op_sub_h,
    op_sub_w,
    op_and_q,
    op_or_q,
    op_xor_q,
    op_nand_q,
    op_ceq_h,
    op_ceq_w,
    op_cgt_h,
    op_cgt_w
  } fx_op_e;

endpackage

/* hw/fx_op_if.sv */
// One decoded operation per cycle with no handshake; the sink must take it every clock
`timescale 1ns/1ns

interface fx_op_if
  import fx_data_pkg::*;
  import fx_isa_pkg::*;
();

  // Decoded operation and its two quadword operands
  fx_op_e    op;
  quad_t     opnd_a;
  quad_t     opnd_b;
  // Target register and its write strobe
  reg_addr_t dest;
  logic      write;

  modport source (output op, output opnd_a, output opnd_b, output dest, output write);

  modport sink (input op, input opnd_a, input opnd_b, input dest, input write);

endinterface

/* hw/fx_decode.sv */
// Combinational decode; RI10 ignores immediate bits above bit 9, flush overrides everything
`timescale 1ns/1ns

module fx_decode
  import fx_data_pkg::*;
  import fx_isa_pkg::*;
(
  input  format_t       instr_format,
  input  opcode_t       op_code,
  input  reg_addr_t     dest_reg_addr,
  input  quad_t         src_reg_a,
  input  quad_t         src_reg_b,
  input  imm_t          imm_value,
  input  logic          enable_reg_write,
  input  logic          branch_is_taken,
  fx_op_if.source       dec
);

  fx_op_e op_sel;
  logic   half_op;
  half_t  imm_half;
  word_t  imm_word;

  // Format and opcode to operation
  always_comb begin
    op_sel = op_none;
    if (instr_format == fmt_rr) begin
      // Opcode 0 here is the nop and lands in default
      case (op_code)
        op_ah:   op_sel = op_add_h;
        op_a:    op_sel = op_add_w;
        op_sfh:  op_sel = op_sub_h;
        op_sf:   op_sel = op_sub_w;
        op_and:  op_sel = op_and_q;
        op_or:   op_sel = op_or_q;
        op_xor:  op_sel = op_xor_q;
        op_nand: op_sel = op_nand_q;
        op_ceqh: op_sel = op_ceq_h;
        op_ceq:  op_sel = op_ceq_w;
        op_cgth: op_sel = op_cgt_h;
        op_cgt:  op_sel = op_cgt_w;
        default: op_sel = op_none;
      endcase
    end else if (instr_format == fmt_ri10) begin
      case (op_code)
        op_ahi:   op_sel = op_add_h;
        op_ai:    op_sel = op_add_w;
        op_sfhi:  op_sel = op_sub_h;
        op_sfi:   op_sel = op_sub_w;
        op_ceqhi: op_sel = op_ceq_h;
        op_ceqi:  op_sel = op_ceq_w;
        op_cgthi: op_sel = op_cgt_h;
        op_cgti:  op_sel = op_cgt_w;
        default:  op_sel = op_none;
      endcase
    end
    // Taken branch squashes whatever was decoded
    if (branch_is_taken) begin
      op_sel = op_none;
    end
  end

  // Halfword-lane operations get the immediate replicated per halfword
  assign half_op = (op_sel == op_add_h) || (op_sel == op_sub_h) ||
                   (op_sel == op_ceq_h) || (op_sel == op_cgt_h);

  // Sign extension of imm10 to lane width
  assign imm_half = {{6{imm_value[9]}}, imm_value[9:0]};
  assign imm_word = {{22{imm_value[9]}}, imm_value[9:0]};

  assign dec.op     = op_sel;
  assign dec.opnd_a = src_reg_a;

  // RI10 replaces source b with the broadcast immediate
  always_comb begin
    if (instr_format == fmt_ri10) begin
      dec.opnd_b = half_op ? {8{imm_half}} : {4{imm_word}};
    end else begin
      dec.opnd_b = src_reg_b;
    end
  end

  // Dropped instructions carry no destination and never write
  assign dec.dest  = (op_sel == op_none) ? '0 : dest_reg_addr;
  assign dec.write = (op_sel == op_none) ? 1'b0 : enable_reg_write;

endmodule

/* hw/fx_issue_reg.sv */
// Holds one decoded operation for one cycle; operands carry no reset, op and dest do
`timescale 1ns/1ns

module fx_issue_reg
  import fx_isa_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  fx_op_if.sink   in_op,
  fx_op_if.source out_op
);

  // Control part, cleared to an idle op
  always_ff @(posedge clock) begin
    if (reset) begin
      out_op.op    <= op_none;
      out_op.dest  <= '0;
      out_op.write <= 1'b0;
    end else begin
      out_op.op    <= in_op.op;
      out_op.dest  <= in_op.dest;
      out_op.write <= in_op.write;
    end
  end

  // Quadword operands
  // Execute ignores them while op is none
  always_ff @(posedge clock) begin
    out_op.opnd_a <= in_op.opnd_a;
    out_op.opnd_b <= in_op.opnd_b;
  end

endmodule

/* hw/fx_execute.sv */
// Signed saturating lane math; op_none yields zero data and the result registers every cycle
`timescale 1ns/1ns

module fx_execute
  import fx_data_pkg::*;
  import fx_isa_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  fx_op_if.sink     in_op,
  output quad_t     wb_data,
  output reg_addr_t wb_reg_addr,
  output logic      wb_enable_reg_write
);

  // One bit wider than a word, enough for any lane sum or difference
  typedef logic signed [32:0] wide_t;

  quad_t half_res;
  quad_t word_res;
  quad_t result;

  // Clamp a widened result into the lane range
  function automatic wide_t clamp(input wide_t value, input wide_t hi, input wide_t lo);
    if (value > hi) return hi;
    if (value < lo) return lo;
    return value;
  endfunction

  // Eight halfword lanes
  for (genvar i = 0; i < 8; i++) begin : g_half
    half_t a_h;
    half_t b_h;
    wide_t sum_h;
    wide_t dif_h;

    assign a_h   = in_op.opnd_a[16*i +: 16];
    assign b_h   = in_op.opnd_b[16*i +: 16];
    assign sum_h = wide_t'(signed'(a_h)) + wide_t'(signed'(b_h));
    // Subtract-from is b minus a
    assign dif_h = wide_t'(signed'(b_h)) - wide_t'(signed'(a_h));

    assign half_res[16*i +: 16] =
      (in_op.op == op_add_h) ?
        half_t'(clamp(sum_h, wide_t'(signed'(half_max)), wide_t'(signed'(half_min)))) :
      (in_op.op == op_sub_h) ?
        half_t'(clamp(dif_h, wide_t'(signed'(half_max)), wide_t'(signed'(half_min)))) :
      (in_op.op == op_ceq_h) ? {16{a_h == b_h}} :
      {16{signed'(a_h) > signed'(b_h)}};
  end

  // Four word lanes
  for (genvar i = 0; i < 4; i++) begin : g_word
    word_t a_w;
    word_t b_w;
    wide_t sum_w;
    wide_t dif_w;

    assign a_w   = in_op.opnd_a[32*i +: 32];
    assign b_w   = in_op.opnd_b[32*i +: 32];
    assign sum_w = wide_t'(signed'(a_w)) + wide_t'(signed'(b_w));
    assign dif_w = wide_t'(signed'(b_w)) - wide_t'(signed'(a_w));

    assign word_res[32*i +: 32] =
      (in_op.op == op_add_w) ?
        word_t'(clamp(sum_w, wide_t'(signed'(word_max)), wide_t'(signed'(word_min)))) :
      (in_op.op == op_sub_w) ?
        word_t'(clamp(dif_w, wide_t'(signed'(word_max)), wide_t'(signed'(word_min)))) :
      (in_op.op == op_ceq_w) ? {32{a_w == b_w}} :
      {32{signed'(a_w) > signed'(b_w)}};
  end

  // Pick lane result or full-width logic
  always_comb begin
    case (in_op.op)
      op_add_h, op_sub_h, op_ceq_h, op_cgt_h: result = half_res;
      op_add_w, op_sub_w, op_ceq_w, op_cgt_w: result = word_res;
      op_and_q:  result = in_op.opnd_a & in_op.opnd_b;
      op_or_q:   result = in_op.opnd_a | in_op.opnd_b;
      op_xor_q:  result = in_op.opnd_a ^ in_op.opnd_b;
      op_nand_q: result = ~(in_op.opnd_a & in_op.opnd_b);
      default:   result = '0;
    endcase
  end

  // Write-back stage
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_data             <= '0;
      wb_reg_addr         <= '0;
      wb_enable_reg_write <= 1'b0;
    end else begin
      wb_data             <= result;
      wb_reg_addr         <= in_op.dest;
      wb_enable_reg_write <= in_op.write;
    end
  end

endmodule

/* hw/simple_fixed.sv */
// Two-edge latency from inputs to write-back, one instruction per cycle, no stall input
`timescale 1ns/1ns

module simple_fixed
  import fx_data_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  format_t   instr_format,
  input  opcode_t   op_code,
  input  reg_addr_t dest_reg_addr,
  input  quad_t     src_reg_a,
  input  quad_t     src_reg_b,
  input  imm_t      imm_value,
  input  logic      enable_reg_write,
  input  logic      branch_is_taken,
  output quad_t     wb_data,
  output reg_addr_t wb_reg_addr,
  output logic      wb_enable_reg_write
);

  // Decode to issue, then issue to execute
  fx_op_if dec_bus ();
  fx_op_if iss_bus ();

  fx_decode i_decode (
    .instr_format     (instr_format),
    .op_code          (op_code),
    .dest_reg_addr    (dest_reg_addr),
    .src_reg_a        (src_reg_a),
    .src_reg_b        (src_reg_b),
    .imm_value        (imm_value),
    .enable_reg_write (enable_reg_write),
    .branch_is_taken  (branch_is_taken),
    .dec              (dec_bus.source)
  );

  // First pipeline edge
  fx_issue_reg i_issue_reg (
    .clock  (clock),
    .reset  (reset),
    .in_op  (dec_bus.sink),
    .out_op (iss_bus.source)
  );

  // Second edge lands in the write-back register
  fx_execute i_execute (
    .clock               (clock),
    .reset               (reset),
    .in_op               (iss_bus.sink),
    .wb_data             (wb_data),
    .wb_reg_addr         (wb_reg_addr),
    .wb_enable_reg_write (wb_enable_reg_write)
  );

endmodule

/* verification/simple_fixed_chk.sv */
// Sampled on the rising clock; address check assumes the fixed two-edge latency
`timescale 1ns/1ns

module simple_fixed_chk
  import fx_data_pkg::*;
(
  input logic      clock,
  input logic      reset,
  input logic      branch_is_taken,
  input reg_addr_t dest_reg_addr,
  input reg_addr_t wb_reg_addr,
  input logic      wb_enable_reg_write
);

  // Failed properties so far
  int fail_count = 0;

  // Write-back register comes out of reset idle
  a_reset_idle: assert property (@(posedge clock) reset |=> !wb_enable_reg_write)
    else begin
      fail_count++;
      $error("wb_enable_reg_write high in the cycle after reset");
    end

  // Flushed instruction never writes
  a_flush_no_write: assert property (@(posedge clock) disable iff (reset)
    branch_is_taken |-> ##2 !wb_enable_reg_write)
    else begin
      fail_count++;
      $error("wb_enable_reg_write high two edges after a taken branch");
    end

  // Destination travels unchanged through both stages
  a_addr_follows: assert property (@(posedge clock) disable iff (reset)
    wb_enable_reg_write |-> wb_reg_addr == $past(dest_reg_addr, 2))
    else begin
      fail_count++;
      $error("wb_reg_addr differs from dest_reg_addr two edges earlier");
    end

endmodule

bind simple_fixed simple_fixed_chk i_chk (.*);

/* verification/simple_fixed_tb.sv */
// Run from the project root so the vector path resolves; stops at the first wrong output
`timescale 1ns/1ns

module simple_fixed_tb
  import fx_data_pkg::*;
  import fx_isa_pkg::*;
();

  // Hex words per vector line
  localparam int fields      = 11;
  localparam int max_vectors = 64;

  logic      clock;
  logic      reset;
  format_t   instr_format;
  opcode_t   op_code;
  reg_addr_t dest_reg_addr;
  quad_t     src_reg_a;
  quad_t     src_reg_b;
  imm_t      imm_value;
  logic      enable_reg_write;
  logic      branch_is_taken;
  quad_t     wb_data;
  reg_addr_t wb_reg_addr;
  logic      wb_enable_reg_write;

  // Raw vector words, unread entries stay unknown
  quad_t       vec_mem [0:fields*max_vectors-1];
  int          n_vectors;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] rng_state;

  // Expected write-back, oldest first, two in flight
  quad_t     exp_data_q [$];
  reg_addr_t exp_addr_q [$];
  logic      exp_write_q [$];

  simple_fixed i_dut (
    .clock               (clock),
    .reset               (reset),
    .instr_format        (instr_format),
    .op_code             (op_code),
    .dest_reg_addr       (dest_reg_addr),
    .src_reg_a           (src_reg_a),
    .src_reg_b           (src_reg_b),
    .imm_value           (imm_value),
    .enable_reg_write    (enable_reg_write),
    .branch_is_taken     (branch_is_taken),
    .wb_data             (wb_data),
    .wb_reg_addr         (wb_reg_addr),
    .wb_enable_reg_write (wb_enable_reg_write)
  );

  // 20 ns period
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on error");
  endtask

  // Limit covers every vector, one nop per vector and the drain
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clock);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        fail_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
      end
    end
  end

  // Any failed property in the bound checker ends the run
  initial begin
    wait (i_dut.i_chk.fail_count != 0);
    fail_run("An assertion in the bound checker failed");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_quad(input string name, input quad_t got, input quad_t expected);
    if (got !== expected) begin
      fail_run($sformatf("Mismatch at %0t ns: %s got %h, expected %h",
                         $time, name, got, expected));
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got,
                            input reg_addr_t expected);
    if (got !== expected) begin
      fail_run($sformatf("Mismatch at %0t ns: %s got %h, expected %h",
                         $time, name, got, expected));
    end
  endtask

  task automatic check_write(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      fail_run($sformatf("Mismatch at %0t ns: %s got %b, expected %b",
                         $time, name, got, expected));
    end
  endtask

  task automatic push_expect(input quad_t data, input reg_addr_t addr, input logic write);
    exp_data_q.push_back(data);
    exp_addr_q.push_back(addr);
    exp_write_q.push_back(write);
  endtask

  // Result of the instruction driven two falling edges ago
  task automatic check_outputs();
    quad_t     data_exp;
    reg_addr_t addr_exp;
    logic      write_exp;
    data_exp  = exp_data_q.pop_front();
    addr_exp  = exp_addr_q.pop_front();
    write_exp = exp_write_q.pop_front();
    check_quad("wb_data", wb_data, data_exp);
    check_addr("wb_reg_addr", wb_reg_addr, addr_exp);
    check_write("wb_enable_reg_write", wb_enable_reg_write, write_exp);
  endtask

  task automatic drive_vector(input int idx);
    int base;
    base = idx * fields;
    instr_format     = format_t'(vec_mem[base]);
    op_code          = opcode_t'(vec_mem[base+1]);
    dest_reg_addr    = reg_addr_t'(vec_mem[base+2]);
    enable_reg_write = vec_mem[base+3][0];
    branch_is_taken  = vec_mem[base+4][0];
    src_reg_a        = vec_mem[base+5];
    src_reg_b        = vec_mem[base+6];
    imm_value        = imm_t'(vec_mem[base+7]);
    push_expect(vec_mem[base+8], reg_addr_t'(vec_mem[base+9]), vec_mem[base+10][0]);
  endtask

  // Nop with random operands and destination, nothing may come out
  task automatic drive_nop();
    rng_state        = xorshift32(rng_state);
    instr_format     = fmt_rr;
    op_code          = '0;
    dest_reg_addr    = reg_addr_t'(rng_state);
    src_reg_a        = {4{rng_state}};
    src_reg_b        = {4{~rng_state}};
    imm_value        = imm_t'(rng_state);
    enable_reg_write = 1'b1;
    branch_is_taken  = 1'b0;
    push_expect('0, '0, 1'b0);
  endtask

  initial begin
    reset            = 1'b1;
    instr_format     = fmt_rr;
    op_code          = '0;
    dest_reg_addr    = '0;
    src_reg_a        = '0;
    src_reg_b        = '0;
    imm_value        = '0;
    enable_reg_write = 1'b0;
    branch_is_taken  = 1'b0;
    rng_state        = 32'hb8eb0d1f;
    n_vectors        = 0;
    cycle_limit      = 0;
    $readmemh("verification/simple_fixed_vectors.txt", vec_mem);
    // First unknown format word ends the list
    while (n_vectors < max_vectors && !$isunknown(vec_mem[n_vectors*fields])) begin
      n_vectors++;
    end
    if (n_vectors == 0) begin
      fail_run("No test vectors were read from the vector file");
    end
    cycle_limit = 2 * n_vectors + 20;
    // Idle outputs expected up to the first result
    push_expect('0, '0, 1'b0);
    push_expect('0, '0, 1'b0);
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int idx = 0; idx < n_vectors; idx++) begin
      check_outputs();
      drive_vector(idx);
      @(negedge clock);
      rng_state = xorshift32(rng_state);
      // Roughly one nop in four
      if (rng_state[1:0] == 2'b00) begin
        check_outputs();
        drive_nop();
        @(negedge clock);
      end
    end
    // Drain the two results still in the pipe
    repeat (2) begin
      check_outputs();
      drive_nop();
      @(negedge clock);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

/* verification/simple_fixed_vectors.txt */
// Columns in hex: format opcode dest write branch src_a src_b imm exp_data exp_addr exp_write
// Quadwords print halfword lane 7 or word lane 3 first
0 0c8 05 1 0 7fff80001234fff04000c00000017000 0001ffff111100204000c000ffff2000 0 7fff8000234500107fff800000007fff 05 1
0 0c0 11 1 0 7fffffff8000000012345678fffffff0 00000001ffffffff1111111100000100 0 7fffffff8000000023456789000000f0 11 1
0 048 22 1 0 00017fff100080000010ffff00004000 8000800030007fff000500000000c000 0 8000800020007ffffff5000100008000 22 1
0 040 33 1 0 000000017fffffff0000100080000000 80000000800000000000300000000000 0 8000000080000000000020007fffffff 33 1
0 0c1 40 1 0 0123456789abcdeffedcba9876543210 ff00ff00f0f0f0f00f0f0f0f12345678 0 0100450080a0c0e00e0c0a0812141210 40 1
0 041 41 0 0 0123456789abcdeffedcba9876543210 ff00ff00f0f0f0f00f0f0f0f12345678 0 ff23ff67f9fbfdffffdfbf9f76747678 41 0
0 241 42 1 0 0123456789abcdeffedcba9876543210 ff00ff00f0f0f0f00f0f0f0f12345678 0 fe23ba67795b3d1ff1d3b59764606468 42 1
0 0c9 43 1 0 0123456789abcdeffedcba9876543210 ff00ff00f0f0f0f00f0f0f0f12345678 0 feffbaff7f5f3f1ff1f3f5f7edebedef 43 1
0 000 7f 1 0 0123456789abcdeffedcba9876543210 ff00ff00f0f0f0f00f0f0f0f12345678 0 0 00 0
0 3c8 50 1 0 123456780000ffff80007fffabcd0001 123456790000fffe80007fffabcd1001 0 ffff0000ffff0000ffffffffffff0000 50 1
0 240 51 1 0 0000000580000000ffffffff7fffffff 000000037fffffff800000007fffffff 0 ffffffff00000000ffffffff00000000 51 1
0 0c8 12 1 1 7fff80001234fff04000c00000017000 0001ffff111100204000c000ffff2000 0 0 00 0
4 01d 60 1 0 8000800100007fff00021234ffff8002 ffffffffffffffffffffffffffffffff 3fffe 80008000fffe7ffd00001232fffd8000 60 1
4 00c 61 1 0 80000000000001ff000002007fffffff 0 1ff 7fffffff00000000ffffffff80000200 61 1
0 7ff 13 1 0 7fffffff8000000012345678fffffff0 00000001ffffffff1111111100000100 0 0 00 0
4 07d 62 1 0 fe000200fe000000fe00fe017e00fe00 0 200 ffff0000ffff0000ffff00000000ffff 62 1
4 04c 63 1 0 00000000ffffffff800000007fffffff 0 3ff ffffffff0000000000000000ffffffff 63 1
2 0c8 14 1 0 7fff80001234fff04000c00000017000 0001ffff111100204000c000ffff2000 0 0 00 0
4 00d 64 1 0 8000000500067fff80050000fffb1000 0 005 7fff0000ffff80067fff0005000af005 64 1
4 04d 65 1 0 0001ffff7fff800000000100fe001234 0 000 ffff0000ffff00000000ffff0000ffff 65 1
4 01c 66 1 0 7fffff0080000000fffffff012345678 0 100 7fffffff80000100000000f012345778 66 1

/* simple_fixed.f */
hw/fx_data_pkg.sv
hw/fx_isa_pkg.sv
hw/fx_op_if.sv
hw/fx_decode.sv
hw/fx_issue_reg.sv
hw/fx_execute.sv
hw/simple_fixed.sv
verification/simple_fixed_chk.sv
verification/simple_fixed_tb.sv

/* Bender.yml */
package:
  name: simple_fixed

sources:
  - hw/fx_data_pkg.sv
  - hw/fx_isa_pkg.sv
  - hw/fx_op_if.sv
  - hw/fx_decode.sv
  - hw/fx_issue_reg.sv
  - hw/fx_execute.sv
  - hw/simple_fixed.sv
  - target: test
    files:
      - verification/simple_fixed_chk.sv
      - verification/simple_fixed_tb.sv
